// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= fsync_4x4_tb
FILELIST   ?= filelist.f
LOG        ?= sim.log
FAIL_MSG   := *** FAILED ***
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
hdl/fsync_pkg.sv
hdl/fsync_leaf.sv
hdl/fsync_pipe.sv
hdl/fsync_root.sv
hdl/fsync_4x4.sv
tests/fsync_4x4_chk.sv
tests/fsync_4x4_tb.sv

// File: hdl/fsync_4x4.sv
/* 4x4 barrier network top: maps grid CUs onto quad leaves,
   links the leaves to the root through the pipe */

`timescale 1ns/1ns

module fsync_4x4 (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [fsync_pkg::N_CUS-1:0]    req_i,
  input  fsync_pkg::sync_lvl_e           lvl_i [fsync_pkg::N_CUS],
  output logic [fsync_pkg::N_CUS-1:0]    ack_o
);

  logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::QUAD_CUS-1:0]  quad_req;
  logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::QUAD_CUS-1:0]  quad_ack;
  fsync_pkg::sync_lvl_e quad_lvl [fsync_pkg::N_QUADS][fsync_pkg::QUAD_CUS];

  logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0] leaf_up_req;
  logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0] leaf_up_ack;
  logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0] root_up_req;
  logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0] root_ack;

  // --------------------------------------------------
  // grid to quad mapping
  // --------------------------------------------------
  for (genvar r = 0; r < fsync_pkg::GRID_DIM; r++) begin : gen_row
    for (genvar c = 0; c < fsync_pkg::GRID_DIM; c++) begin : gen_col
      // quad from the upper row/col bits, local cu from the lower ones
      assign quad_req[(r/2)*(fsync_pkg::GRID_DIM/2) + c/2][(r%2)*2 + c%2] =
        req_i[r*fsync_pkg::GRID_DIM + c];
      assign quad_lvl[(r/2)*(fsync_pkg::GRID_DIM/2) + c/2][(r%2)*2 + c%2] =
        lvl_i[r*fsync_pkg::GRID_DIM + c];
      assign ack_o[r*fsync_pkg::GRID_DIM + c] =
        quad_ack[(r/2)*(fsync_pkg::GRID_DIM/2) + c/2][(r%2)*2 + c%2];
    end
  end

  // --------------------------------------------------
  // leaves, pipe, root
  // --------------------------------------------------
  for (genvar q = 0; q < fsync_pkg::N_QUADS; q++) begin : gen_leaf
    fsync_leaf i_leaf (
      .clk_i    ( clk_i          ),
      .rst_i    ( rst_i          ),
      .req_i    ( quad_req[q]    ),
      .lvl_i    ( quad_lvl[q]    ),
      .ack_o    ( quad_ack[q]    ),
      .up_req_o ( leaf_up_req[q] ),
      .up_ack_i ( leaf_up_ack[q] )
    );
  end

  fsync_pipe i_pipe (
    .clk_i    ( clk_i       ),
    .rst_i    ( rst_i       ),
    .up_req_i ( leaf_up_req ),
    .up_req_o ( root_up_req ),
    .dn_ack_i ( root_ack    ),
    .dn_ack_o ( leaf_up_ack )
  );

  fsync_root i_root (
    .clk_i    ( clk_i       ),
    .rst_i    ( rst_i       ),
    .up_req_i ( root_up_req ),
    .ack_o    ( root_ack    )  // top of the tree
  );

endmodule

// File: hdl/fsync_leaf.sv
/* quad leaf node: registers four CU requests, resolves pair and quad barriers
   and runs the four-phase handshake towards the root for the upper levels */

`timescale 1ns/1ns

module fsync_leaf (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [fsync_pkg::QUAD_CUS-1:0]        req_i,
  input  fsync_pkg::sync_lvl_e                  lvl_i [fsync_pkg::QUAD_CUS],
  output logic [fsync_pkg::QUAD_CUS-1:0]        ack_o,
  output logic [fsync_pkg::N_UP_LVLS-1:0]       up_req_o,
  input  logic [fsync_pkg::N_UP_LVLS-1:0]       up_ack_i
);

  logic [fsync_pkg::QUAD_CUS-1:0]  req_q;
  logic [fsync_pkg::QUAD_CUS-1:0]  wake_q;
  logic [fsync_pkg::QUAD_CUS-1:0]  fresh;    // requesting and not yet woken
  logic [fsync_pkg::QUAD_CUS-1:0]  set_cu;
  fsync_pkg::sync_lvl_e            lvl_q [fsync_pkg::QUAD_CUS];
  logic                            quad_all;
  logic [fsync_pkg::N_UP_LVLS-1:0] arrive;
  logic [fsync_pkg::N_UP_LVLS-1:0] held;     // some CU still holds a woken request
  fsync_pkg::arrive_state_e        state_q [fsync_pkg::N_UP_LVLS];
  fsync_pkg::arrive_state_e        state_d [fsync_pkg::N_UP_LVLS];

  // --------------------------------------------------
  // input register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q <= '0;
    end else begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    lvl_q <= lvl_i;
  end

  assign fresh = req_q & ~wake_q;

  // --------------------------------------------------
  // group completion
  // --------------------------------------------------
  always_comb begin
    quad_all = 1'b1;
    arrive   = '1;
    held     = '0;
    for (int i = 0; i < fsync_pkg::QUAD_CUS; i++) begin
      if (!fresh[i] || lvl_q[i] != fsync_pkg::LVL_QUAD) quad_all = 1'b0;
      for (int l = 0; l < fsync_pkg::N_UP_LVLS; l++) begin
        // upper level index l stands for LVL_HALF + l
        if (!fresh[i] || int'(lvl_q[i]) != int'(fsync_pkg::LVL_HALF) + l) arrive[l] = 1'b0;
        if (wake_q[i] && int'(lvl_q[i]) == int'(fsync_pkg::LVL_HALF) + l) held[l] = 1'b1;
      end
    end

    for (int i = 0; i < fsync_pkg::QUAD_CUS; i++) begin
      // partner of a pair sits in the same row, local index differs in bit 0
      set_cu[i] = (lvl_q[i] == fsync_pkg::LVL_PAIR && fresh[i ^ 1] &&
                   lvl_q[i ^ 1] == fsync_pkg::LVL_PAIR) ||
                  (lvl_q[i] == fsync_pkg::LVL_QUAD && quad_all);
      for (int l = 0; l < fsync_pkg::N_UP_LVLS; l++) begin
        if (int'(lvl_q[i]) == int'(fsync_pkg::LVL_HALF) + l &&
            state_q[l] == fsync_pkg::ST_UP && up_ack_i[l]) begin
          set_cu[i] = 1'b1;
        end
      end
      set_cu[i] = set_cu[i] && fresh[i];
    end
  end

  // wake stays up until the CU releases its request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wake_q <= '0;
    end else begin
      wake_q <= req_q & (wake_q | set_cu);
    end
  end

  assign ack_o = wake_q;

  // --------------------------------------------------
  // upward handshake FSMs
  // --------------------------------------------------
  always_comb begin
    for (int l = 0; l < fsync_pkg::N_UP_LVLS; l++) begin
      state_d[l] = state_q[l];
      case (state_q[l])
        fsync_pkg::ST_IDLE: if (arrive[l])    state_d[l] = fsync_pkg::ST_UP;
        fsync_pkg::ST_UP:   if (up_ack_i[l])  state_d[l] = fsync_pkg::ST_WAKE;
        fsync_pkg::ST_WAKE: if (!held[l])     state_d[l] = fsync_pkg::ST_DROP;
        fsync_pkg::ST_DROP: if (!up_ack_i[l]) state_d[l] = fsync_pkg::ST_IDLE;
        default:                              state_d[l] = fsync_pkg::ST_IDLE;
      endcase
      // request held up to the root until the local CUs let go
      up_req_o[l] = state_q[l] == fsync_pkg::ST_UP || state_q[l] == fsync_pkg::ST_WAKE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int l = 0; l < fsync_pkg::N_UP_LVLS; l++) begin
        state_q[l] <= fsync_pkg::ST_IDLE;
      end
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: hdl/fsync_pipe.sv
/* register pipeline between the quad leaves and the root,
   requests travel up and acknowledges down through the same stages */

`timescale 1ns/1ns

module fsync_pipe (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  input  logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0]   up_req_i,
  output logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0]   up_req_o,
  input  logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0]   dn_ack_i,
  output logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0]   dn_ack_o
);

  // both directions side by side, upper half carries the requests
  logic [1:0][fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0] stage_q [fsync_pkg::PIPE_STAGES];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < fsync_pkg::PIPE_STAGES; s++) begin
        stage_q[s] <= '0;
      end
    end else begin
      stage_q[0] <= {up_req_i, dn_ack_i};
      for (int s = 1; s < fsync_pkg::PIPE_STAGES; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign {up_req_o, dn_ack_o} = stage_q[fsync_pkg::PIPE_STAGES-1];

endmodule

// File: hdl/fsync_pkg.sv
/* grid sizes, latency constants, level enum and the FSM state enums
   shared by the 4x4 barrier network */

package fsync_pkg;

  // --------------------------------------------------
  // grid geometry
  // --------------------------------------------------
  localparam int unsigned GRID_DIM  = 4;                    // CUs per row and per column
  localparam int unsigned N_CUS     = GRID_DIM * GRID_DIM;  // cu index = row*GRID_DIM + col
  localparam int unsigned QUAD_CUS  = 4;
  // quad = (row/2)*2 + col/2, local cu = (row%2)*2 + col%2
  localparam int unsigned N_QUADS   = N_CUS / QUAD_CUS;
  localparam int unsigned N_UP_LVLS = 2;                    // half and all, resolved in the root

  // --------------------------------------------------
  // pipeline and latency
  // --------------------------------------------------
  localparam int unsigned PIPE_STAGES   = 1;                  // per direction
  localparam int unsigned LOCAL_LATENCY = 1;
  // leaf FSM, pipe up, root ack, pipe down, wake register
  localparam int unsigned UP_LATENCY    = 3 + 2 * PIPE_STAGES;

  // barrier level requested by a CU
  typedef enum logic [1:0] {
    LVL_PAIR,  // horizontal pair in a quad
    LVL_QUAD,
    LVL_HALF,  // two quads side by side
    LVL_ALL
  } sync_lvl_e;

  // leaf upward handshake, one per upper level
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_UP,
    ST_WAKE,
    ST_DROP
  } arrive_state_e;

  // root group state
  typedef enum logic {
    GRP_WAIT,
    GRP_ACK
  } group_state_e;

endpackage

// File: hdl/fsync_root.sv
/* root node: one group FSM per half for level 2 and one for level 3,
   acknowledges fan back out to every member quad */

`timescale 1ns/1ns

module fsync_root (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  input  logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0]   up_req_i,
  output logic [fsync_pkg::N_QUADS-1:0][fsync_pkg::N_UP_LVLS-1:0]   ack_o
);

  // groups 0 .. N_QUADS/2-1 are the halves, group N_QUADS/2 is the whole grid
  logic [fsync_pkg::N_QUADS/2:0] grp_hi;  // all members requesting
  logic [fsync_pkg::N_QUADS/2:0] grp_lo;  // all members released
  fsync_pkg::group_state_e       grp_q [fsync_pkg::N_QUADS/2+1];

  function automatic fsync_pkg::group_state_e grp_next(fsync_pkg::group_state_e st,
                                                       logic hi, logic lo);
    if (st == fsync_pkg::GRP_WAIT && hi) return fsync_pkg::GRP_ACK;
    if (st == fsync_pkg::GRP_ACK && lo) return fsync_pkg::GRP_WAIT;
    return st;
  endfunction

  // --------------------------------------------------
  // member collection
  // --------------------------------------------------
  always_comb begin
    grp_hi = '1;
    grp_lo = '1;
    for (int q = 0; q < fsync_pkg::N_QUADS; q++) begin
      if (!up_req_i[q][0]) grp_hi[q/2] = 1'b0;  // quads 0,1 top, 2,3 bottom
      if (up_req_i[q][0])  grp_lo[q/2] = 1'b0;
      if (!up_req_i[q][1]) grp_hi[fsync_pkg::N_QUADS/2] = 1'b0;
      if (up_req_i[q][1])  grp_lo[fsync_pkg::N_QUADS/2] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int g = 0; g <= fsync_pkg::N_QUADS/2; g++) begin
      if (rst_i) begin
        grp_q[g] <= fsync_pkg::GRP_WAIT;
      end else begin
        grp_q[g] <= grp_next(grp_q[g], grp_hi[g], grp_lo[g]);
      end
    end
  end

  // --------------------------------------------------
  // acknowledge fan-out
  // --------------------------------------------------
  always_comb begin
    for (int q = 0; q < fsync_pkg::N_QUADS; q++) begin
      ack_o[q][0] = grp_q[q/2] == fsync_pkg::GRP_ACK;
      ack_o[q][1] = grp_q[fsync_pkg::N_QUADS/2] == fsync_pkg::GRP_ACK;
    end
  end

endmodule

// File: tests/fsync_4x4_chk.sv
/* bound assertions: handshake order, group agreement, latency and release */

`timescale 1ns/1ns

module fsync_4x4_chk (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic [fsync_pkg::N_CUS-1:0]   req_i,
  input fsync_pkg::sync_lvl_e          lvl_i [fsync_pkg::N_CUS],
  input logic [fsync_pkg::N_CUS-1:0]   ack_o
);

  logic [fsync_pkg::N_CUS-1:0] members [fsync_pkg::N_CUS];
  logic [fsync_pkg::N_CUS-1:0] grp_full;  // whole group requesting at one level
  logic [fsync_pkg::N_CUS-1:0] req_seen;  // req_i high at least once since reset

  // --------------------------------------------------
  // group membership from grid position
  // --------------------------------------------------
  always_comb begin
    for (int n = 0; n < fsync_pkg::N_CUS; n++) begin
      grp_full[n] = 1'b1;
      for (int m = 0; m < fsync_pkg::N_CUS; m++) begin
        case (lvl_i[n])
          fsync_pkg::LVL_PAIR: members[n][m] = (n / 4 == m / 4) && ((n % 4) / 2 == (m % 4) / 2);
          fsync_pkg::LVL_QUAD: members[n][m] = (n / 8 == m / 8) && ((n % 4) / 2 == (m % 4) / 2);
          fsync_pkg::LVL_HALF: members[n][m] = n / 8 == m / 8;
          default:             members[n][m] = 1'b1;
        endcase
        if (members[n][m] && (!req_i[m] || lvl_i[m] != lvl_i[n])) grp_full[n] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_seen <= '0;
    end else begin
      req_seen <= req_seen | req_i;
    end
  end

  for (genvar n = 0; n < fsync_pkg::N_CUS; n++) begin : gen_cu
    a_ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_o[n] |-> req_seen[n])
      else $error("cu %0d ack high before any req after reset", n);

    a_rise: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(ack_o[n]) |-> $past(req_i[n]))
      else $error("cu %0d ack rose without req", n);

    a_fall: assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(ack_o[n]) |-> !$past(req_i[n]))
      else $error("cu %0d ack fell while req high", n);

    a_group: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(ack_o[n]) |-> (ack_o & members[n]) == members[n] && $past(grp_full[n]))
      else $error("cu %0d group not complete or not acked together", n);

    a_local_lat: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(ack_o[n]) && lvl_i[n] inside {fsync_pkg::LVL_PAIR, fsync_pkg::LVL_QUAD} |->
        $past(grp_full[n], fsync_pkg::LOCAL_LATENCY + 1) &&
        !$past(grp_full[n], fsync_pkg::LOCAL_LATENCY + 2))
      else $error("cu %0d local latency wrong", n);

    a_up_lat: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(ack_o[n]) && lvl_i[n] inside {fsync_pkg::LVL_HALF, fsync_pkg::LVL_ALL} |->
        $past(grp_full[n], fsync_pkg::UP_LATENCY + 1))
      else $error("cu %0d upper level acked too early", n);

    a_release: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_o[n] && !req_i[n] && $past(req_i[n]) |=> ack_o[n] ##1 !ack_o[n])
      else $error("cu %0d release timing wrong", n);
  end

endmodule

bind fsync_4x4 fsync_4x4_chk i_chk (
  .clk_i ( clk_i ),
  .rst_i ( rst_i ),
  .req_i ( req_i ),
  .lvl_i ( lvl_i ),
  .ack_o ( ack_o )
);

// File: tests/fsync_4x4_tb.sv
/* testbench for the 4x4 barrier network: clock, reset, LFSR-driven CU models,
   group check on every ack rise, cycle timeout and the final verdict */

`timescale 1ns/1ns

module fsync_4x4_tb;

  localparam int ROUNDS    = 40;
  localparam int MAX_CYCLE = ROUNDS * (fsync_pkg::UP_LATENCY + 20);

  logic                         clk_i;
  logic                         rst_i;
  logic [fsync_pkg::N_CUS-1:0]  req_i;
  fsync_pkg::sync_lvl_e         lvl_i [fsync_pkg::N_CUS];
  logic [fsync_pkg::N_CUS-1:0]  ack_o;
  logic [fsync_pkg::N_CUS-1:0]  ack_seen;
  logic [31:0]                  lfsr_q;
  int                           cycle_cnt;

  fsync_4x4 i_fsync_4x4 (
    .clk_i ( clk_i ),
    .rst_i ( rst_i ),
    .req_i ( req_i ),
    .lvl_i ( lvl_i ),
    .ack_o ( ack_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [7:0] rand_bits(int n);
    logic [7:0] val;
    logic       fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[6:0], fb};
    end
    return val;
  endfunction

  // is cu b in the group of cu a at level l
  function automatic bit in_group(int a, int b, fsync_pkg::sync_lvl_e l);
    case (l)
      fsync_pkg::LVL_PAIR: return (a / 4 == b / 4) && ((a % 4) / 2 == (b % 4) / 2);
      fsync_pkg::LVL_QUAD: return (a / 8 == b / 8) && ((a % 4) / 2 == (b % 4) / 2);
      fsync_pkg::LVL_HALF: return a / 8 == b / 8;
      default:             return 1'b1;
    endcase
  endfunction

  task automatic stop_failed();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on failure");
  endtask

  task automatic report_mismatch(string msg);
    $display("ERROR %0t ns: %s", $time, msg);
    stop_failed();
  endtask

  // one four-phase transaction of a CU model, entered 1 ns after a rising edge
  task automatic cu_cycle(int n, int dly);
    repeat (dly) begin
      @(posedge clk_i);
      #1;
    end
    req_i[n] = 1'b1;
    do begin
      @(posedge clk_i);
      #1;
    end while (!ack_o[n]);
    req_i[n] = 1'b0;
    do begin
      @(posedge clk_i);
      #1;
    end while (ack_o[n]);
  endtask

  // every member of the group must see ack on the same edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      for (int n = 0; n < fsync_pkg::N_CUS; n++) begin
        if (ack_o[n] && !ack_seen[n]) begin
          for (int m = 0; m < fsync_pkg::N_CUS; m++) begin
            if (in_group(n, m, lvl_i[n])) begin
              assert (ack_o[m] && lvl_i[m] == lvl_i[n])
                else report_mismatch($sformatf("cu %0d acked without group member %0d", n, m));
            end
          end
        end
      end
    end
    ack_seen = ack_o;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLE) begin
      $display("timeout: the barrier network stopped making progress");
      stop_failed();
    end
  end

  initial begin
    int                   dly [fsync_pkg::N_CUS];
    fsync_pkg::sync_lvl_e half_lvl [2];
    lfsr_q    = 32'h6f6d;
    cycle_cnt = 0;
    ack_seen  = '0;
    rst_i     = 1'b1;
    req_i     = '0;
    for (int n = 0; n < fsync_pkg::N_CUS; n++) lvl_i[n] = fsync_pkg::LVL_PAIR;
    repeat (8) @(posedge clk_i);
    #1 rst_i = 1'b0;

    for (int r = 0; r < ROUNDS; r++) begin
      // one level per half, the full barrier forces both halves
      half_lvl[0] = fsync_pkg::sync_lvl_e'(rand_bits(2));
      half_lvl[1] = fsync_pkg::sync_lvl_e'(rand_bits(2));
      if (half_lvl[0] == fsync_pkg::LVL_ALL || half_lvl[1] == fsync_pkg::LVL_ALL) begin
        half_lvl[0] = fsync_pkg::LVL_ALL;
        half_lvl[1] = fsync_pkg::LVL_ALL;
      end
      for (int n = 0; n < fsync_pkg::N_CUS; n++) begin
        lvl_i[n] = half_lvl[n / 8];
        dly[n]   = int'(rand_bits(3));
      end
      for (int n = 0; n < fsync_pkg::N_CUS; n++) begin
        fork
          automatic int k = n;
          cu_cycle(k, dly[k]);
        join_none
      end
      wait fork;
    end

    repeat (4) @(posedge clk_i);
    $display("*** PASSED ***");
    $finish;
  end

endmodule
